// ==== files.f ====
+incdir+.
rv_ex_pkg.sv
rv_div_if.sv
rv_alu.sv
rv_branch.sv
rv_div.sv
rv_stage_ex.sv
rv_ex_clkgen.sv
rv_ex_sva.sv
rv_ex_tb.sv

// ==== rv_ex_tb.sv ====
`include "rv_ex_cfg.svh"

module rv_ex_tb;
  import rv_ex_pkg::*;

  // Stimulus fields in the order of the drive concatenation
  typedef struct packed {
    logic       reg_write;
    reg_idx_t   rd;
    a_src_t     a_src;
    logic       b_src;
    alu_instr_t alu_instr;
    funct3_t    f3;
    logic       f7;
    logic       opb5;
    logic       br;
    logic       jmp;
    logic       jbs;
    logic       dv;
    xlen_t      rs1;
    xlen_t      rs2;
    xlen_t      imm;
    xlen_t      pc;
    logic       stall;
  } stim_t;

  typedef struct packed {
    stim_t s;
    xlen_t alu;
    logic  sel;
    xlen_t target;
    xlen_t div;
  } entry_t;

  logic clk, rst_n, ex_mem_stall, reg_write, alu_b_src, funct7_b5, op_b5;
  logic is_branch, is_jump, jb_target_src, is_div;
  logic pc_sel, op_active, reg_write_mem, is_div_mem;
  reg_idx_t rd, rd_mem;
  a_src_t alu_a_src;
  alu_instr_t alu_instr;
  funct3_t funct3;
  xlen_t rs1_data, rs2_data, imm, pc, pc_redirect_target;
  xlen_t alu_result_mem, jb_target_mem, div_result_mem;

  entry_t tbl[$];
  entry_t held = '0;
  xlen_t held_div = '0;
  xlen_t last_div = '0;
  int errors = 0;
  int active;
  logic built = 1'b0;
  integer seed = 32'hc9a356bd;
  funct3_t br_f3[6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
  // Equal pair then small negative against one and the reverse
  xlen_t op_a[3] = '{32'd5, 32'hffff_ffff, 32'd1};
  xlen_t op_b[3] = '{32'd5, 32'd1, 32'hffff_ffff};

  rv_ex_clkgen clkgen_inst (.clk(clk), .rst_n(rst_n));

  rv_stage_ex rv_stage_ex_inst (.*);

  // RV32I ALU behavior
  function automatic xlen_t alu_model(stim_t s);
    xlen_t a, b;
    a = (s.a_src == A_SRC_ZERO) ? '0 : (s.a_src == A_SRC_PC) ? s.pc : s.rs1;
    b = s.b_src ? s.imm : s.rs2;
    if (s.alu_instr == ALU_INSTR_ADD) return a + b;
    if (s.alu_instr == ALU_INSTR_SUB) return a - b;
    case (s.f3)
      3'd0: return (s.f7 && s.opb5) ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return xlen_t'($signed(a) < $signed(b));
      3'd3: return xlen_t'(a < b);
      3'd4: return a ^ b;
      3'd5: begin
        if (s.f7) return xlen_t'($signed(a) >>> b[4:0]);
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_model(stim_t s);
    case (s.f3)
      F3_BEQ:  return s.rs1 == s.rs2;
      F3_BNE:  return s.rs1 != s.rs2;
      F3_BLT:  return $signed(s.rs1) < $signed(s.rs2);
      F3_BGE:  return $signed(s.rs1) >= $signed(s.rs2);
      F3_BLTU: return s.rs1 < s.rs2;
      F3_BGEU: return s.rs1 >= s.rs2;
      default: return 1'b0;
    endcase
  endfunction

  // M extension results with zero divisor and overflow cases
  function automatic xlen_t div_model(funct3_t op, xlen_t a, xlen_t b);
    xlen_t q, r;
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (!op[0] && a == 32'h8000_0000 && b == '1) begin
      q = a;
      r = '0;
    end else if (!op[0]) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    return op[1] ? r : q;
  endfunction

  // kind is {branch, jump, jalr target, divide}
  task automatic add_entry(a_src_t as, logic bs, alu_instr_t ai, funct3_t f3,
                           logic [1:0] f7ob, logic [3:0] kind, xlen_t a, xlen_t b,
                           xlen_t im, logic stall);
    entry_t e;
    e.s = '{reg_write: !kind[3], rd: reg_idx_t'(tbl.size()), a_src: as, b_src: bs,
            alu_instr: ai, f3: f3, f7: f7ob[1], opb5: f7ob[0], br: kind[3],
            jmp: kind[2], jbs: kind[1], dv: kind[0], rs1: a, rs2: b, imm: im,
            pc: xlen_t'($random(seed)) & ~xlen_t'(3), stall: stall};
    e.alu = alu_model(e.s);
    e.sel = (e.s.br && branch_model(e.s)) || e.s.jmp;
    e.target = e.s.jbs ? (e.alu & ~xlen_t'(1)) : e.s.pc + e.s.imm;
    e.div = div_model(f3, a, b);
    tbl.push_back(e);
  endtask

  // Called right after a rising edge
  task automatic drive(stim_t s);
    {reg_write, rd, alu_a_src, alu_b_src, alu_instr, funct3, funct7_b5, op_b5,
     is_branch, is_jump, jb_target_src, is_div, rs1_data, rs2_data, imm, pc,
     ex_mem_stall} <= s;
  endtask

  task automatic check(string what, xlen_t got, xlen_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic verify_ex_mem(entry_t h, xlen_t hdiv);
    check("reg_write_mem", reg_write_mem, h.s.reg_write);
    check("rd_mem", rd_mem, h.s.rd);
    check("is_div_mem", is_div_mem, h.s.dv);
    check("alu_result_mem", alu_result_mem, h.alu);
    check("jb_target_mem", jb_target_mem, h.target);
    check("div_result_mem", div_result_mem, hdiv);
  endtask

  // Run limit scales with the table length
  initial begin
    wait (built);
    #((tbl.size() + 8) * (`RV_DIV_STEPS + 4) * 8);
    $display("Timeout: the stage did not get through all entries in time");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    // Nonzero fields under stall so only reset can clear EX/MEM
    drive('{dv: 1'b0, default: '1});
    // Every R-type funct3 with funct7 bit 5 low and high
    for (int k = 0; k < 16; k++)
      add_entry(A_SRC_RS1, 0, ALU_INSTR_FUNCT, funct3_t'(k), {k[3], 1'b1}, 4'b0000,
                $random(seed), $random(seed), $random(seed), 0);
    add_entry(A_SRC_RS1, 0, ALU_INSTR_FUNCT, 3'd5, 2'b11, 0, 32'h8000_0f00, 4, 0, 0);
    add_entry(A_SRC_RS1, 0, ALU_INSTR_FUNCT, 3'd2, 2'b01, 0, '1, 1, 0, 0);
    // ADDI keeps add even with funct7 bit 5 set
    add_entry(A_SRC_RS1, 1, ALU_INSTR_FUNCT, 3'd0, 2'b10, 0, $random(seed), 0,
              $random(seed), 0);
    // LUI then AUIPC
    add_entry(A_SRC_ZERO, 1, ALU_INSTR_ADD, 0, 0, 0, $random(seed), 0, 32'habcde000, 0);
    add_entry(A_SRC_PC, 1, ALU_INSTR_ADD, 0, 0, 0, $random(seed), 0, 32'h00012000, 0);
    // Stalled entry must not reach EX/MEM
    add_entry(A_SRC_RS1, 0, ALU_INSTR_FUNCT, 3'd4, 2'b01, 0, $random(seed),
              $random(seed), 0, 1);
    for (int k = 0; k < 6; k++)
      for (int p = 0; p < 3; p++)
        add_entry(A_SRC_RS1, 0, ALU_INSTR_SUB, br_f3[k], 0, 4'b1000, op_a[p], op_b[p],
                  $random(seed), 0);
    // JAL then JALR with an odd sum
    add_entry(A_SRC_PC, 1, ALU_INSTR_ADD, 0, 0, 4'b0100, 0, 0, $random(seed), 0);
    add_entry(A_SRC_RS1, 1, ALU_INSTR_ADD, 0, 0, 4'b0110, 32'h1000_0001, 0, 32'h10, 0);
    for (int k = 4; k < 8; k++) begin
      add_entry(A_SRC_RS1, 0, ALU_INSTR_FUNCT, funct3_t'(k), 2'b01, 4'b0001,
                $random(seed), $random(seed), 0, 0);
      add_entry(A_SRC_RS1, 0, ALU_INSTR_FUNCT, funct3_t'(k), 2'b01, 4'b0001,
                $random(seed), xlen_t'($random(seed)) >> 28, 0, 0);
      add_entry(A_SRC_RS1, 0, ALU_INSTR_FUNCT, funct3_t'(k), 2'b01, 4'b0001,
                $random(seed), 0, 0, 0);
      add_entry(A_SRC_RS1, 0, ALU_INSTR_FUNCT, funct3_t'(k), 2'b01, 4'b0001,
                32'h8000_0000, '1, 0, 0);
    end
    add_entry(A_SRC_RS1, 0, ALU_INSTR_FUNCT, 3'd6, 2'b01, 0, $random(seed),
              $random(seed), 0, 1);
    built = 1'b1;

    wait (rst_n === 1'b1);
    @(negedge clk);
    check("op_active after reset", op_active, 0);
    verify_ex_mem(held, held_div);

    for (int i = 0; i < tbl.size(); i++) begin
      @(posedge clk);
      drive(tbl[i].s);
      @(negedge clk);
      // This edge stored the previous entry
      verify_ex_mem(held, held_div);
      check("pc_sel", pc_sel, tbl[i].sel);
      check("pc_redirect_target", pc_redirect_target, tbl[i].target);
      if (tbl[i].s.dv) begin
        active = 0;
        while (op_active) begin
          active++;
          @(negedge clk);
        end
        check("op_active cycles", active, `RV_DIV_STEPS + 1);
        last_div = tbl[i].div;
      end
      if (!tbl[i].s.stall) begin
        held = tbl[i];
        held_div = last_div;
      end
    end
    @(posedge clk);
    drive('0);
    @(negedge clk);
    verify_ex_mem(held, held_div);

    errors += rv_stage_ex_inst.rv_ex_sva_inst.fails;
    $display("Finished %0d entries with %0d errors", tbl.size(), errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// ==== rv_ex_sva.sv ====
`include "rv_ex_cfg.svh"

module rv_ex_sva (
  input logic                clk,
  input logic                rst_n,
  input logic                ex_mem_stall,
  input logic                op_active,
  input logic                reg_write_mem,
  input rv_ex_pkg::reg_idx_t rd_mem,
  input logic                is_div_mem,
  input rv_ex_pkg::xlen_t    alu_result_mem,
  input rv_ex_pkg::xlen_t    jb_target_mem,
  input rv_ex_pkg::xlen_t    div_result_mem
);

  // Failure count, read by the testbench at the end
  int fails = 0;

  // No divide in flight once reset lets go
  a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !op_active)
    else begin
      $error("op_active high in the first cycle after reset");
      fails++;
    end

  // Start cycle plus one per divider step, never longer
  a_active_len: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(op_active) |-> ##[1:`RV_DIV_STEPS+1] !op_active)
    else begin
      $error("op_active stayed high too long");
      fails++;
    end

  // Stall freezes the whole EX/MEM register
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ex_mem_stall |=> $stable({reg_write_mem, rd_mem, is_div_mem, alu_result_mem,
                              jb_target_mem, div_result_mem}))
    else begin
      $error("EX/MEM outputs changed under stall");
      fails++;
    end

endmodule

bind rv_stage_ex rv_ex_sva rv_ex_sva_inst (.*);

// ==== rv_ex_clkgen.sv ====
module rv_ex_clkgen (
  output logic clk,
  output logic rst_n
);

  // 8 unit period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset held low over the first 4 rising edges
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== rv_stage_ex.sv ====
module rv_stage_ex (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ex_mem_stall,
  input  logic                  reg_write,
  input  rv_ex_pkg::reg_idx_t   rd,
  input  rv_ex_pkg::a_src_t     alu_a_src,
  input  logic                  alu_b_src,
  input  rv_ex_pkg::alu_instr_t alu_instr,
  input  rv_ex_pkg::funct3_t    funct3,
  input  logic                  funct7_b5,
  input  logic                  op_b5,
  input  logic                  is_branch,
  input  logic                  is_jump,
  input  logic                  jb_target_src,
  input  logic                  is_div,
  input  rv_ex_pkg::xlen_t      rs1_data,
  input  rv_ex_pkg::xlen_t      rs2_data,
  input  rv_ex_pkg::xlen_t      imm,
  input  rv_ex_pkg::xlen_t      pc,
  output logic                  pc_sel,
  output rv_ex_pkg::xlen_t      pc_redirect_target,
  output logic                  op_active,
  output logic                  reg_write_mem,
  output rv_ex_pkg::reg_idx_t   rd_mem,
  output logic                  is_div_mem,
  output rv_ex_pkg::xlen_t      alu_result_mem,
  output rv_ex_pkg::xlen_t      jb_target_mem,
  output rv_ex_pkg::xlen_t      div_result_mem
);
  import rv_ex_pkg::*;

  // Divider sequencing
  typedef enum logic {
    IDLE,
    EXEC
  } mc_state_t;

  mc_state_t state;
  mc_state_t state_next;

  xlen_t alu_a;
  xlen_t alu_b;
  xlen_t alu_result;
  xlen_t m_result;

  rv_div_if div_if ();

  // ALU A: rs1, zero for LUI, pc for AUIPC
  always_comb begin
    case (alu_a_src)
      A_SRC_RS1:  alu_a = rs1_data;
      A_SRC_ZERO: alu_a = '0;
      A_SRC_PC:   alu_a = pc;
      default:    alu_a = rs1_data;
    endcase
  end

  // ALU B: rs2 or immediate
  assign alu_b = alu_b_src ? imm : rs2_data;

  rv_alu rv_alu_inst (
    .alu_instr(alu_instr),
    .funct3   (funct3),
    .funct7_b5(funct7_b5),
    .op_b5    (op_b5),
    .a        (alu_a),
    .b        (alu_b),
    .result   (alu_result)
  );

  // Compare on raw register operands
  rv_branch rv_branch_inst (
    .rs1          (rs1_data),
    .rs2          (rs2_data),
    .funct3       (funct3),
    .is_branch    (is_branch),
    .is_jump      (is_jump),
    .jb_target_src(jb_target_src),
    .pc           (pc),
    .imm          (imm),
    .alu_result   (alu_result),
    .pc_sel       (pc_sel),
    .target       (pc_redirect_target)
  );

  // Start strobe in IDLE, then track divider busy
  always_comb begin
    state_next = state;
    op_active  = 1'b0;
    div_if.en  = 1'b0;
    case (state)
      IDLE: begin
        if (is_div) begin
          div_if.en  = 1'b1;
          op_active  = 1'b1;
          state_next = EXEC;
        end
      end
      EXEC: begin
        // First low cycle has the result on m_result
        op_active = div_if.busy;
        if (!div_if.busy) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign div_if.op       = funct3;
  assign div_if.dividend = rs1_data;
  assign div_if.divisor  = rs2_data;
  assign m_result        = div_if.result;

  rv_div rv_div_inst (
    .clk  (clk),
    .rst_n(rst_n),
    .div  (div_if.div)
  );

  // EX/MEM register, frozen while stalled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_write_mem  <= 1'b0;
      rd_mem         <= '0;
      is_div_mem     <= 1'b0;
      alu_result_mem <= '0;
      jb_target_mem  <= '0;
      div_result_mem <= '0;
    end else if (!ex_mem_stall) begin
      reg_write_mem  <= reg_write;
      rd_mem         <= rd;
      is_div_mem     <= is_div;
      alu_result_mem <= alu_result;
      jb_target_mem  <= pc_redirect_target;
      div_result_mem <= m_result;
    end
  end

endmodule

// ==== rv_div.sv ====
`include "rv_ex_cfg.svh"

module rv_div (
  input logic   clk,
  input logic   rst_n,
  rv_div_if.div div
);
  import rv_ex_pkg::*;

  localparam int CNT_W = $clog2(`RV_DIV_STEPS);

  // Iteration state
  logic [CNT_W-1:0] cnt;
  xlen_t            quo;
  xlen_t            rem;
  xlen_t            dvs;
  // Sign correction and result select, fixed at start
  logic             neg_quo;
  logic             neg_rem;
  logic             rem_sel;

  logic              op_signed;
  logic              op_rem;
  logic              sign_a;
  logic              sign_b;
  xlen_t             abs_dividend;
  xlen_t             abs_divisor;
  logic [`RV_XLEN:0] shifted;
  logic [`RV_XLEN:0] diff;

  // Operation decode
  always_comb begin
    case (div.op)
      F3_DIV:  {op_signed, op_rem} = 2'b10;
      F3_DIVU: {op_signed, op_rem} = 2'b00;
      F3_REM:  {op_signed, op_rem} = 2'b11;
      default: {op_signed, op_rem} = 2'b01;
    endcase
  end

  assign sign_a       = op_signed && div.dividend[`RV_XLEN-1];
  assign sign_b       = op_signed && div.divisor[`RV_XLEN-1];
  assign abs_dividend = sign_a ? -div.dividend : div.dividend;
  assign abs_divisor  = sign_b ? -div.divisor : div.divisor;

  // Bring in next dividend bit and try the subtraction
  assign shifted = {rem, quo[`RV_XLEN-1]};
  assign diff    = shifted - {1'b0, dvs};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div.busy <= 1'b0;
      cnt      <= '0;
      quo      <= '0;
      rem      <= '0;
      dvs      <= '0;
      neg_quo  <= 1'b0;
      neg_rem  <= 1'b0;
      rem_sel  <= 1'b0;
    end else if (div.en) begin
      div.busy <= 1'b1;
      cnt      <= '0;
      quo      <= abs_dividend;
      rem      <= '0;
      dvs      <= abs_divisor;
      // Zero divisor keeps the all-ones quotient unsigned
      neg_quo  <= (sign_a ^ sign_b) && (div.divisor != '0);
      // Remainder takes the dividend sign
      neg_rem  <= sign_a;
      rem_sel  <= op_rem;
    end else if (div.busy) begin
      cnt <= cnt + 1'b1;
      // Restore on borrow, keep the difference otherwise
      if (!diff[`RV_XLEN]) begin
        rem <= diff[`RV_XLEN-1:0];
        quo <= {quo[`RV_XLEN-2:0], 1'b1};
      end else begin
        rem <= shifted[`RV_XLEN-1:0];
        quo <= {quo[`RV_XLEN-2:0], 1'b0};
      end
      if (cnt == CNT_W'(`RV_DIV_STEPS - 1)) begin
        div.busy <= 1'b0;
      end
    end
  end

  // Divide by zero falls out as all-ones quotient, remainder = dividend
  // Most negative by -1 wraps back to the dividend with zero remainder
  assign div.result = rem_sel ? (neg_rem ? -rem : rem) : (neg_quo ? -quo : quo);

endmodule

// ==== rv_branch.sv ====
module rv_branch (
  input  rv_ex_pkg::xlen_t   rs1,
  input  rv_ex_pkg::xlen_t   rs2,
  input  rv_ex_pkg::funct3_t funct3,
  input  logic               is_branch,
  input  logic               is_jump,
  input  logic               jb_target_src,
  input  rv_ex_pkg::xlen_t   pc,
  input  rv_ex_pkg::xlen_t   imm,
  input  rv_ex_pkg::xlen_t   alu_result,
  output logic               pc_sel,
  output rv_ex_pkg::xlen_t   target
);
  import rv_ex_pkg::*;

  logic taken;

  // Branch condition from funct3
  always_comb begin
    case (funct3)
      F3_BEQ:  taken = (rs1 == rs2);
      F3_BNE:  taken = (rs1 != rs2);
      F3_BLT:  taken = ($signed(rs1) < $signed(rs2));
      F3_BGE:  taken = ($signed(rs1) >= $signed(rs2));
      F3_BLTU: taken = (rs1 < rs2);
      F3_BGEU: taken = (rs1 >= rs2);
      // Reserved encodings never branch
      default: taken = 1'b0;
    endcase
  end

  // No predictor, so any jump or taken branch redirects
  assign pc_sel = (is_branch && taken) || is_jump;

  // JAL and branches are pc relative
  // JALR uses rs1 + imm from the ALU with bit 0 cleared
  assign target = jb_target_src ? (alu_result & ~xlen_t'(1)) : (pc + imm);

endmodule

// ==== rv_alu.sv ====
module rv_alu (
  input  rv_ex_pkg::alu_instr_t alu_instr,
  input  rv_ex_pkg::funct3_t    funct3,
  input  logic                  funct7_b5,
  input  logic                  op_b5,
  input  rv_ex_pkg::xlen_t      a,
  input  rv_ex_pkg::xlen_t      b,
  output rv_ex_pkg::xlen_t      result
);
  import rv_ex_pkg::*;

  alu_op_t    alu_op;
  logic [4:0] shamt;

  // Operation decode, RV32I style
  always_comb begin
    case (alu_instr)
      ALU_INSTR_ADD: alu_op = ALU_ADD;
      ALU_INSTR_SUB: alu_op = ALU_SUB;
      ALU_INSTR_FUNCT: begin
        case (funct3)
          // SUB only for R-type, ADDI ignores funct7
          3'b000:  alu_op = (funct7_b5 && op_b5) ? ALU_SUB : ALU_ADD;
          3'b001:  alu_op = ALU_SLL;
          3'b010:  alu_op = ALU_SLT;
          3'b011:  alu_op = ALU_SLTU;
          3'b100:  alu_op = ALU_XOR;
          // SRAI keeps funct7 bit 5 in the immediate too
          3'b101:  alu_op = funct7_b5 ? ALU_SRA : ALU_SRL;
          3'b110:  alu_op = ALU_OR;
          default: alu_op = ALU_AND;
        endcase
      end
      default: alu_op = ALU_ADD;
    endcase
  end

  // Shift amount from low bits of B only
  assign shamt = b[4:0];

  // Datapath
  always_comb begin
    case (alu_op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_SLL: result = a << shamt;
      // Set-less-than yields 0 or 1
      ALU_SLT: result = xlen_t'($signed(a) < $signed(b));
      ALU_SLTU: result = xlen_t'(a < b);
      ALU_XOR: result = a ^ b;
      ALU_SRL: result = a >> shamt;
      // Sign fill from A
      ALU_SRA: result = xlen_t'($signed(a) >>> shamt);
      ALU_OR: result = a | b;
      ALU_AND: result = a & b;
      default: result = a + b;
    endcase
  end

endmodule

// ==== rv_div_if.sv ====
interface rv_div_if;
  import rv_ex_pkg::*;

  // One-cycle start strobe, operands sampled with it
  logic    en;
  funct3_t op;
  xlen_t   dividend;
  xlen_t   divisor;
  // Level, high while iterating
  logic    busy;
  // Valid once busy falls, held until next start
  xlen_t   result;

  modport stage (
    output en, op, dividend, divisor,
    input  busy, result
  );

  modport div (
    input  en, op, dividend, divisor,
    output busy, result
  );

endinterface

// ==== rv_ex_pkg.sv ====
`include "rv_ex_cfg.svh"

package rv_ex_pkg;

  // Operand, result and address word
  typedef logic [`RV_XLEN-1:0] xlen_t;
  // Destination register index
  typedef logic [`RV_REGW-1:0] reg_idx_t;
  // Instruction funct3 field
  typedef logic [2:0] funct3_t;

  // ALU operation codes
  typedef logic [3:0] alu_op_t;
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_OR   = 4'd8;
  localparam alu_op_t ALU_AND  = 4'd9;

  // Decode class from the ID stage
  typedef logic [1:0] alu_instr_t;
  localparam alu_instr_t ALU_INSTR_ADD   = 2'd0;
  localparam alu_instr_t ALU_INSTR_SUB   = 2'd1;
  localparam alu_instr_t ALU_INSTR_FUNCT = 2'd2;

  // ALU A operand source
  typedef logic [1:0] a_src_t;
  localparam a_src_t A_SRC_RS1  = 2'd0;
  localparam a_src_t A_SRC_ZERO = 2'd1;
  localparam a_src_t A_SRC_PC   = 2'd2;

  // Branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // M extension divide operations
  localparam funct3_t F3_DIV  = 3'b100;
  localparam funct3_t F3_DIVU = 3'b101;
  localparam funct3_t F3_REM  = 3'b110;
  localparam funct3_t F3_REMU = 3'b111;

endpackage

// ==== rv_ex_cfg.svh ====
`ifndef RV_EX_CFG_SVH
`define RV_EX_CFG_SVH

// Integer data path width
`define RV_XLEN 32

// Register file index width
`define RV_REGW 5

// Divider produces one quotient bit per iteration
`define RV_DIV_STEPS `RV_XLEN

`endif
